// ==== dv/clk_gen.sv ====
`timescale 1ns/1ps

module clk_gen (
	output logic clk,
	output logic rst
);

	initial begin
		clk = 1'b0;
		forever #4 clk = ~clk;
	end

	// reset held for 16 rising edges
	initial begin
		rst = 1'b1;
		repeat (16) @(posedge clk);
		rst <= 1'b0;
	end

endmodule

// ==== dv/dcache_props.sv ====
`timescale 1ns/1ps

module dcache_props (
	input logic                  clk,
	input logic                  rst,
	input logic                  req_valid,
	input logic                  ready,
	input logic                  arvalid,
	input logic                  arready,
	input dcache_pkg::ar_req_t   ar,
	input logic                  wr_valid,
	input logic                  wr_ready,
	input dcache_pkg::wr_req_t   wr
);

	ar_held: assert property (@(posedge clk) disable iff (rst)
		arvalid && !arready |=> arvalid && $stable(ar))
		else $error("read request dropped or changed before arready");

	wr_held: assert property (@(posedge clk) disable iff (rst)
		wr_valid && !wr_ready |=> wr_valid && $stable(wr))
		else $error("write request dropped or changed before wr_ready");

	ready_pulse: assert property (@(posedge clk) disable iff (rst)
		ready |=> !ready)
		else $error("ready lasted two cycles");

	ready_with_req: assert property (@(posedge clk) disable iff (rst)
		ready |-> req_valid)
		else $error("ready without a request");

	// first edge of reset only clears the registers
	quiet_in_reset: assert property (@(posedge clk)
		rst && $past(rst) |-> !ready && !arvalid && !wr_valid)
		else $error("handshake output active during reset");

endmodule

bind dcache_top dcache_props u_props (
	.clk       (clk),
	.rst       (rst),
	.req_valid (req_valid),
	.ready     (ready),
	.arvalid   (arvalid),
	.arready   (arready),
	.ar        (ar),
	.wr_valid  (wr_valid),
	.wr_ready  (wr_ready),
	.wr        (wr)
);

// ==== dv/dcache_tb.sv ====
`timescale 1ns/1ps

module dcache_tb;

	logic clk;
	logic rst;
	logic stall;
	logic req_valid;
	dcache_pkg::cpu_req_t req;
	logic ready;
	dcache_pkg::data_t rdata;
	logic arvalid;
	dcache_pkg::ar_req_t ar;
	logic arready;
	logic rvalid;
	dcache_pkg::r_beat_t r;
	logic rready;
	logic wr_valid;
	dcache_pkg::wr_req_t wr;
	logic wr_ready;

	dcache_pkg::bus_t shadow [1024];
	int errors = 0;
	int checks = 0;
	int ar_count = 0;
	int wr_count = 0;
	int num_reqs = 17;
	dcache_pkg::ar_req_t last_ar;
	dcache_pkg::wr_req_t last_wr;
	logic [31:0] rand_state = 32'd12708;
	logic [31:0] stall_state = 32'd12708 ^ 32'h5555;

	clk_gen u_clk (.clk(clk), .rst(rst));

	mem_model u_mem (
		.clk(clk), .rst(rst), .stall(stall),
		.arvalid(arvalid), .ar(ar), .arready(arready),
		.rvalid(rvalid), .r(r), .rready(rready),
		.wr_valid(wr_valid), .wr(wr), .wr_ready(wr_ready)
	);

	dcache_top uut (
		.clk(clk), .rst(rst), .req_valid(req_valid), .req(req),
		.ready(ready), .rdata(rdata),
		.arvalid(arvalid), .ar(ar), .arready(arready),
		.rvalid(rvalid), .r(r), .rready(rready),
		.wr_valid(wr_valid), .wr(wr), .wr_ready(wr_ready)
	);

	function automatic logic [31:0] lcg_step(input logic [31:0] s);
		return s * 32'd1103515245 + 32'd12345;
	endfunction

	// same address hash as the memory model
	function automatic dcache_pkg::bus_t start_word(input int unsigned idx);
		return (idx * 32'h9E37_79B1) ^ 32'hC3A5_0000 ^ (idx << 20);
	endfunction

	function automatic dcache_pkg::data_t expected_read(input dcache_pkg::addr_t a);
		return {shadow[{a[11:3], 1'b1}], shadow[{a[11:3], 1'b0}]};
	endfunction

	task automatic check_value(input string name, input logic [63:0] got,
			input logic [63:0] exp);
		checks++;
		assert (got === exp) else begin
			errors++;
			$display("ERR %s got %h expected %h", name, got, exp);
		end
	endtask

	task automatic check_true(input string what, input bit cond);
		checks++;
		assert (cond) else begin
			errors++;
			$display("failed: %s", what);
		end
	endtask

	// drive one request and hold it until ready
	// lat counts falling edges up to ready
	task automatic access(input dcache_pkg::addr_t a, input logic we,
			input dcache_pkg::data_t wd, input dcache_pkg::strb_t st,
			output dcache_pkg::data_t rd, output int lat);
		@(posedge clk);
		req_valid <= 1'b1;
		req <= '{addr: a, wren: we, wdata: wd, strb: st};
		lat = 0;
		do begin
			@(negedge clk);
			lat++;
		end while (!ready);
		rd = rdata;
		@(posedge clk);
		req_valid <= 1'b0;
	endtask

	task automatic read_check(input dcache_pkg::addr_t a, input int exp_ars, output int lat);
		dcache_pkg::data_t rd;
		int ars;
		ars = ar_count;
		access(a, 1'b0, '0, '0, rd, lat);
		check_value("rdata", rd, expected_read(a));
		if (exp_ars >= 0) begin
			check_value("ar count", ar_count - ars, exp_ars);
		end
	endtask

	always @(posedge clk) begin
		stall_state = lcg_step(stall_state);
		stall <= stall_state[17:16] == 2'b00;
		if (arvalid && arready) begin
			ar_count++;
			last_ar = ar;
		end
		if (wr_valid && wr_ready) begin
			wr_count++;
			last_wr = wr;
		end
	end

	initial begin
		#((16 + num_reqs * 40) * 8);
		$display("timeout: the cache stopped answering requests");
		$display("Checks failed");
		$finish;
	end

	initial begin
		dcache_pkg::data_t rd;
		dcache_pkg::data_t wd;
		dcache_pkg::strb_t st;
		dcache_pkg::addr_t a;
		int lat;
		int ars;
		int wrs;
		req_valid = 1'b0;
		req = '0;
		for (int i = 0; i < 1024; i++) begin
			shadow[i] = start_word(i);
		end
		// quiet through reset and the first idle cycle
		do begin
			@(negedge clk);
			check_value("reset outputs", {ready, arvalid, rready, wr_valid}, 4'b0000);
		end while (rst);
		@(negedge clk);
		check_value("idle outputs", {ready, arvalid, rready, wr_valid}, 4'b0000);

		read_check(32'h0000_0108, 1, lat);
		check_value("ar.addr", last_ar.addr, 32'h0000_0100);
		check_value("ar.len", last_ar.len, 15);
		read_check(32'h0000_0130, 0, lat);
		check_value("hit latency", lat - 1, 1);

		rand_state = lcg_step(rand_state);
		wd[63:32] = rand_state;
		rand_state = lcg_step(rand_state);
		wd[31:0] = rand_state;
		st = rand_state[23:16];
		if (st == '0) begin
			st = 8'h0F;
		end
		a = 32'h0000_0118;
		wrs = wr_count;
		access(a, 1'b1, wd, st, rd, lat);
		check_value("wr count", wr_count - wrs, 1);
		check_value("wr.addr", last_wr.addr, a);
		check_value("wr.data", last_wr.data, wd);
		check_value("wr.strb", last_wr.strb, st);
		for (int b = 0; b < 8; b++) begin
			if (st[b]) begin
				shadow[{a[11:3], b[2]}][8*b[1:0] +: 8] = wd[8*b +: 8];
			end
		end
		read_check(a, 1, lat);

		// device space is never allocated
		read_check(32'h9000_0300, 1, lat);
		check_value("ar.len", last_ar.len, 1);
		check_value("ar.addr", last_ar.addr, 32'h9000_0300);
		read_check(32'h9000_0300, 1, lat);
		check_value("ar.len", last_ar.len, 1);
		read_check(32'h9000_0808, 1, lat);
		check_value("ar.len", last_ar.len, 1);
		check_value("ar.addr", last_ar.addr, 32'h9000_0808);

		// five tags in set 5
		for (int k = 0; k < 5; k++) begin
			read_check(32'h0000_0140 + k * 32'h400 + k * 8, -1, lat);
		end
		ars = ar_count;
		for (int k = 0; k < 5; k++) begin
			read_check(32'h0000_0140 + k * 32'h400 + k * 8, -1, lat);
		end
		check_true("no refill among re-reads of five tags in one set", ar_count > ars);

		repeat (4) @(posedge clk);
		$display("checks %0d errors %0d", checks, errors);
		if (errors == 0) begin
			$display("All checks passed");
		end else begin
			$display("Checks failed");
		end
		$finish;
	end

endmodule

// ==== dv/mem_model.sv ====
`timescale 1ns/1ps

module mem_model (
	input  logic                   clk,
	input  logic                   rst,
	input  logic                   stall,
	input  logic                   arvalid,
	input  dcache_pkg::ar_req_t    ar,
	output logic                   arready,
	output logic                   rvalid,
	output dcache_pkg::r_beat_t    r,
	input  logic                   rready,
	input  logic                   wr_valid,
	input  dcache_pkg::wr_req_t    wr,
	output logic                   wr_ready
);

	// 4 KB where upper address bits alias
	dcache_pkg::bus_t words [1024];
	logic busy;
	dcache_pkg::addr_t rd_addr;
	logic [8:0] left;

	function automatic dcache_pkg::bus_t fill_pattern(input int unsigned idx);
		return (idx * 32'h9E37_79B1) ^ 32'hC3A5_0000 ^ (idx << 20);
	endfunction

	initial begin
		arready = 1'b0;
		rvalid = 1'b0;
		r = '0;
		wr_ready = 1'b0;
		for (int i = 0; i < 1024; i++) begin
			words[i] = fill_pattern(i);
		end
	end

	always @(posedge clk) begin
		if (rst) begin
			arready <= 1'b0;
			rvalid <= 1'b0;
			r <= '0;
			busy <= 1'b0;
			left <= '0;
			wr_ready <= 1'b0;
		end else begin
			arready <= 1'b0;
			if (!busy && arvalid && !arready && !stall) begin
				arready <= 1'b1;
			end
			if (arvalid && arready) begin
				busy <= 1'b1;
				rd_addr <= ar.addr;
				left <= ar.len + 9'd1;
			end
			if (rvalid && rready) begin
				rvalid <= 1'b0;
				if (r.last) begin
					busy <= 1'b0;
				end
			end
			// at most one beat per cycle unless stalled
			if (busy && left != 0 && (!rvalid || rready) && !stall) begin
				rvalid <= 1'b1;
				r.data <= words[rd_addr[11:2]];
				r.last <= left == 9'd1;
				rd_addr <= rd_addr + 32'd4;
				left <= left - 9'd1;
			end
			wr_ready <= 1'b0;
			if (wr_valid && !wr_ready && !stall) begin
				wr_ready <= 1'b1;
			end
			if (wr_valid && wr_ready) begin
				for (int b = 0; b < 8; b++) begin
					if (wr.strb[b]) begin
						words[{wr.addr[11:3], b[2]}][8*b[1:0] +: 8] <= wr.data[8*b +: 8];
					end
				end
			end
		end
	end

endmodule

// ==== logic/dcache_ctrl.sv ====
`timescale 1ns/1ps

module dcache_ctrl (
	input  logic                   clk,
	input  logic                   rst,
	input  logic                   req_valid,
	input  dcache_pkg::cpu_req_t   req,
	input  dcache_pkg::way_t       way_hit,
	output logic                   cmd_valid,
	output dcache_pkg::mem_cmd_t   cmd,
	input  logic                   done,
	input  dcache_pkg::data_t      unc_data,
	input  dcache_pkg::data_t      cache_rdata,
	output dcache_pkg::way_t       fill_way,
	output logic                   tag_fill,
	output logic                   tag_inval,
	output logic                   ready,
	output dcache_pkg::data_t      rdata
);

	dcache_pkg::ctrl_state_t state;
	dcache_pkg::way_t victim;
	logic unc_sel;
	logic uncached;
	logic hit;
	logic lookup;

	assign uncached = req.addr >= dcache_pkg::UNCACHED_BASE;
	assign hit = |way_hit;

	// a request is looked at once; the ready cycle itself is skipped
	assign lookup = (state == dcache_pkg::ST_IDLE) && req_valid && !ready;

	// anything but a cached read hit goes to memory
	assign cmd_valid = lookup && (req.wren || uncached || !hit);

	always_comb begin
		if (req.wren) begin
			cmd.kind = dcache_pkg::MEM_WRITE;
		end else if (uncached) begin
			cmd.kind = dcache_pkg::MEM_UNCACHED;
		end else begin
			cmd.kind = dcache_pkg::MEM_REFILL;
		end
		cmd.addr = req.addr;
		cmd.data = req.wdata;
		cmd.strb = req.strb;
	end

	assign tag_inval = lookup && req.wren;
	assign tag_fill = (state == dcache_pkg::ST_REFILL) && done;
	assign fill_way = victim;

	assign rdata = unc_sel ? unc_data : cache_rdata;

	always_ff @(posedge clk) begin
		if (rst) begin
			state <= dcache_pkg::ST_IDLE;
			ready <= 1'b0;
			unc_sel <= 1'b0;
		end else begin
			ready <= 1'b0;
			case (state)
				dcache_pkg::ST_IDLE: begin
					if (cmd_valid) begin
						case (cmd.kind)
							dcache_pkg::MEM_WRITE: state <= dcache_pkg::ST_WRITE;
							dcache_pkg::MEM_UNCACHED: state <= dcache_pkg::ST_UNCACHED;
							default: state <= dcache_pkg::ST_REFILL;
						endcase
					end else if (lookup) begin
						// read hit
						ready <= 1'b1;
						unc_sel <= 1'b0;
					end
				end
				dcache_pkg::ST_REFILL: begin
					// back to idle, the held request then hits
					if (done) begin
						state <= dcache_pkg::ST_IDLE;
					end
				end
				dcache_pkg::ST_UNCACHED: begin
					if (done) begin
						state <= dcache_pkg::ST_IDLE;
						ready <= 1'b1;
						unc_sel <= 1'b1;
					end
				end
				dcache_pkg::ST_WRITE: begin
					if (done) begin
						state <= dcache_pkg::ST_IDLE;
						ready <= 1'b1;
						unc_sel <= 1'b0;
					end
				end
				default: state <= dcache_pkg::ST_IDLE;
			endcase
		end
	end

	// victim pointer rotates while idle, held during a refill
	always_ff @(posedge clk) begin
		if (rst) begin
			victim <= dcache_pkg::way_t'(1);
		end else if (state == dcache_pkg::ST_IDLE) begin
			victim <= {victim[dcache_pkg::WAYS-2:0], victim[dcache_pkg::WAYS-1]};
		end
	end

endmodule

// ==== logic/dcache_data.sv ====
`timescale 1ns/1ps

module dcache_data (
	input  logic                  clk,
	input  dcache_pkg::addr_t     addr,
	input  dcache_pkg::way_t      way_hit,
	input  logic                  fill_valid,
	input  dcache_pkg::fill_t     fill,
	input  dcache_pkg::way_t      fill_way,
	output dcache_pkg::data_t     rdata
);

	dcache_pkg::index_t index;
	logic [dcache_pkg::INDEX_W+dcache_pkg::SLOT_W-1:0] rd_row;
	logic [dcache_pkg::INDEX_W+dcache_pkg::SLOT_W-1:0] wr_row;

	// 64 rows of 128 bits per way
	dcache_pkg::line_word_t mem [dcache_pkg::WAYS][2**(dcache_pkg::INDEX_W+dcache_pkg::SLOT_W)];
	dcache_pkg::line_word_t rd_word [dcache_pkg::WAYS];
	dcache_pkg::line_word_t sel_word;
	dcache_pkg::way_t hit_q;
	logic half_q;

	assign index = addr[dcache_pkg::OFFSET_W +: dcache_pkg::INDEX_W];
	assign rd_row = {index, addr[dcache_pkg::OFFSET_W-dcache_pkg::SLOT_W +: dcache_pkg::SLOT_W]};
	assign wr_row = {index, fill.slot};

	always_ff @(posedge clk) begin
		for (int w = 0; w < dcache_pkg::WAYS; w++) begin
			if (fill_valid && fill_way[w]) begin
				mem[w][wr_row] <= fill.word;
			end
			rd_word[w] <= mem[w][rd_row];
		end
		// way and half travel with the read
		hit_q <= way_hit;
		half_q <= addr[dcache_pkg::OFFSET_W-dcache_pkg::SLOT_W-1];
	end

	// one-hot mux over the registered hit way
	always_comb begin
		sel_word = '0;
		for (int w = 0; w < dcache_pkg::WAYS; w++) begin
			if (hit_q[w]) begin
				sel_word = sel_word | rd_word[w];
			end
		end
	end

	assign rdata = half_q ? sel_word[127:64] : sel_word[63:0];

endmodule

// ==== logic/dcache_mem_port.sv ====
`timescale 1ns/1ps

module dcache_mem_port (
	input  logic                   clk,
	input  logic                   rst,
	input  logic                   cmd_valid,
	input  dcache_pkg::mem_cmd_t   cmd,
	output logic                   done,
	output logic                   arvalid,
	output dcache_pkg::ar_req_t    ar,
	input  logic                   arready,
	input  logic                   rvalid,
	input  dcache_pkg::r_beat_t    r,
	output logic                   rready,
	output logic                   wr_valid,
	output dcache_pkg::wr_req_t    wr,
	input  logic                   wr_ready,
	output logic                   fill_valid,
	output dcache_pkg::fill_t      fill,
	output dcache_pkg::data_t      unc_data
);

	logic rd_busy;
	logic is_unc;
	logic beat;
	logic [$clog2(dcache_pkg::REFILL_LEN)-1:0] beat_cnt;
	// earlier beats of the current 128-bit word, newest on top
	logic [$bits(dcache_pkg::line_word_t)-dcache_pkg::BUS_W-1:0] sh;

	assign rready = rd_busy;
	assign beat = rd_busy && rvalid;
	assign done = (beat && r.last) || (wr_valid && wr_ready);

	// every fourth beat completes a word
	assign fill_valid = beat && !is_unc && (beat_cnt[1:0] == 2'b11);
	assign fill.word = {r.data, sh};
	assign fill.slot = dcache_pkg::slot_t'(beat_cnt >> 2);

	always_ff @(posedge clk) begin
		if (rst) begin
			arvalid <= 1'b0;
			rd_busy <= 1'b0;
			wr_valid <= 1'b0;
			is_unc <= 1'b0;
			beat_cnt <= '0;
		end else begin
			if (cmd_valid && cmd.kind != dcache_pkg::MEM_WRITE) begin
				arvalid <= 1'b1;
				rd_busy <= 1'b1;
				is_unc <= cmd.kind == dcache_pkg::MEM_UNCACHED;
				beat_cnt <= '0;
			end else begin
				if (arvalid && arready) begin
					arvalid <= 1'b0;
				end
				if (beat) begin
					beat_cnt <= beat_cnt + 1'b1;
					if (r.last) begin
						rd_busy <= 1'b0;
					end
				end
			end
			if (cmd_valid && cmd.kind == dcache_pkg::MEM_WRITE) begin
				wr_valid <= 1'b1;
			end else if (wr_ready) begin
				wr_valid <= 1'b0;
			end
		end
	end

	always_ff @(posedge clk) begin
		if (cmd_valid) begin
			if (cmd.kind == dcache_pkg::MEM_UNCACHED) begin
				ar.addr <= cmd.addr;
				ar.len <= dcache_pkg::beat_len_t'(dcache_pkg::UNCACHED_LEN - 1);
			end else begin
				// line aligned, whole line
				ar.addr <= cmd.addr &
					~dcache_pkg::addr_t'((dcache_pkg::BUS_W / 8) * dcache_pkg::REFILL_LEN - 1);
				ar.len <= dcache_pkg::beat_len_t'(dcache_pkg::REFILL_LEN - 1);
			end
			wr.addr <= cmd.addr;
			wr.data <= cmd.data;
			wr.strb <= cmd.strb;
		end
		if (beat) begin
			sh <= {r.data, sh[$high(sh):dcache_pkg::BUS_W]};
			if (is_unc && r.last) begin
				// low half arrived on the previous beat
				unc_data <= {r.data, sh[$high(sh) -: dcache_pkg::BUS_W]};
			end
		end
	end

endmodule

// ==== logic/dcache_pkg.sv ====
package dcache_pkg;

	// cache geometry
	localparam int ADDR_W = 32;
	localparam int DATA_W = 64;
	localparam int BUS_W = 32;
	localparam int WAYS = 4;
	localparam int INDEX_W = 4;
	localparam int TAG_W = 22;
	localparam int SLOT_W = 2;
	// byte offset inside a 64-byte line
	localparam int OFFSET_W = ADDR_W - TAG_W - INDEX_W;

	// burst lengths in beats
	localparam int REFILL_LEN = 16;
	localparam int UNCACHED_LEN = 2;

	typedef logic [ADDR_W-1:0] addr_t;
	typedef logic [DATA_W-1:0] data_t;
	typedef logic [DATA_W/8-1:0] strb_t;
	typedef logic [BUS_W-1:0] bus_t;
	typedef logic [TAG_W-1:0] tag_t;
	typedef logic [INDEX_W-1:0] index_t;
	typedef logic [SLOT_W-1:0] slot_t;
	typedef logic [WAYS-1:0] way_t;
	typedef logic [127:0] line_word_t;
	typedef logic [7:0] beat_len_t;

	// everything from here up is device space
	localparam addr_t UNCACHED_BASE = 32'h9000_0000;

	typedef struct packed {
		addr_t addr;
		logic wren;
		data_t wdata;
		strb_t strb;
	} cpu_req_t;

	// len is beats minus one
	typedef struct packed {
		addr_t addr;
		beat_len_t len;
	} ar_req_t;

	typedef struct packed {
		bus_t data;
		logic last;
	} r_beat_t;

	typedef struct packed {
		addr_t addr;
		data_t data;
		strb_t strb;
	} wr_req_t;

	typedef enum logic [1:0] {
		MEM_REFILL,
		MEM_UNCACHED,
		MEM_WRITE
	} mem_kind_t;

	typedef struct packed {
		mem_kind_t kind;
		addr_t addr;
		data_t data;
		strb_t strb;
	} mem_cmd_t;

	typedef struct packed {
		line_word_t word;
		slot_t slot;
	} fill_t;

	typedef enum logic [1:0] {
		ST_IDLE,
		ST_REFILL,
		ST_UNCACHED,
		ST_WRITE
	} ctrl_state_t;

endpackage

// ==== logic/dcache_tags.sv ====
`timescale 1ns/1ps

module dcache_tags (
	input  logic                clk,
	input  logic                rst,
	input  dcache_pkg::addr_t   addr,
	output dcache_pkg::way_t    way_hit,
	input  logic                fill,
	input  dcache_pkg::way_t    fill_way,
	input  logic                inval
);

	dcache_pkg::index_t index;
	dcache_pkg::tag_t tag;
	dcache_pkg::way_t tag_match;

	// one tag per set and way
	dcache_pkg::tag_t tag_mem [dcache_pkg::WAYS][2**dcache_pkg::INDEX_W];
	logic [2**dcache_pkg::INDEX_W-1:0] valid [dcache_pkg::WAYS];

	assign index = addr[dcache_pkg::OFFSET_W +: dcache_pkg::INDEX_W];
	assign tag = addr[dcache_pkg::OFFSET_W + dcache_pkg::INDEX_W +: dcache_pkg::TAG_W];

	// compare all ways of the selected set in parallel
	always_comb begin
		for (int w = 0; w < dcache_pkg::WAYS; w++) begin
			tag_match[w] = tag_mem[w][index] == tag;
			way_hit[w] = valid[w][index] && tag_match[w];
		end
	end

	// tag written only by a refill, into the victim way
	always_ff @(posedge clk) begin
		for (int w = 0; w < dcache_pkg::WAYS; w++) begin
			if (fill && fill_way[w]) begin
				tag_mem[w][index] <= tag;
			end
		end
	end

	// valid bits
	always_ff @(posedge clk) begin
		if (rst) begin
			for (int w = 0; w < dcache_pkg::WAYS; w++) begin
				valid[w] <= '0;
			end
		end else begin
			for (int w = 0; w < dcache_pkg::WAYS; w++) begin
				if (fill && fill_way[w]) begin
					valid[w][index] <= 1'b1;
				end else if (inval && tag_match[w]) begin
					// write-through, no allocate: drop the stale copy
					valid[w][index] <= 1'b0;
				end
			end
		end
	end

endmodule

// ==== logic/dcache_top.sv ====
`timescale 1ns/1ps

module dcache_top (
	input  logic                   clk,
	input  logic                   rst,
	input  logic                   req_valid,
	input  dcache_pkg::cpu_req_t   req,
	output logic                   ready,
	output dcache_pkg::data_t      rdata,
	output logic                   arvalid,
	output dcache_pkg::ar_req_t    ar,
	input  logic                   arready,
	input  logic                   rvalid,
	input  dcache_pkg::r_beat_t    r,
	output logic                   rready,
	output logic                   wr_valid,
	output dcache_pkg::wr_req_t    wr,
	input  logic                   wr_ready
);

	dcache_pkg::way_t way_hit;
	dcache_pkg::way_t fill_way;
	logic tag_fill;
	logic tag_inval;
	logic cmd_valid;
	dcache_pkg::mem_cmd_t cmd;
	logic done;
	logic fill_valid;
	dcache_pkg::fill_t fill;
	dcache_pkg::data_t unc_data;
	dcache_pkg::data_t cache_rdata;

	dcache_tags u_tags (
		.clk      (clk),
		.rst      (rst),
		.addr     (req.addr),
		.way_hit  (way_hit),
		.fill     (tag_fill),
		.fill_way (fill_way),
		.inval    (tag_inval)
	);

	dcache_ctrl u_ctrl (
		.clk         (clk),
		.rst         (rst),
		.req_valid   (req_valid),
		.req         (req),
		.way_hit     (way_hit),
		.cmd_valid   (cmd_valid),
		.cmd         (cmd),
		.done        (done),
		.unc_data    (unc_data),
		.cache_rdata (cache_rdata),
		.fill_way    (fill_way),
		.tag_fill    (tag_fill),
		.tag_inval   (tag_inval),
		.ready       (ready),
		.rdata       (rdata)
	);

	dcache_data u_data (
		.clk        (clk),
		.addr       (req.addr),
		.way_hit    (way_hit),
		.fill_valid (fill_valid),
		.fill       (fill),
		.fill_way   (fill_way),
		.rdata      (cache_rdata)
	);

	dcache_mem_port u_mem_port (
		.clk        (clk),
		.rst        (rst),
		.cmd_valid  (cmd_valid),
		.cmd        (cmd),
		.done       (done),
		.arvalid    (arvalid),
		.ar         (ar),
		.arready    (arready),
		.rvalid     (rvalid),
		.r          (r),
		.rready     (rready),
		.wr_valid   (wr_valid),
		.wr         (wr),
		.wr_ready   (wr_ready),
		.fill_valid (fill_valid),
		.fill       (fill),
		.unc_data   (unc_data)
	);

endmodule

// ==== run.sh ====
#!/usr/bin/env bash
set -u

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -Wno-fatal \
	--top-module dcache_tb -Mdir obj_dir -f sim.f
if [ $? -ne 0 ]; then
	echo "verilator build failed"
	exit 1
fi

out=$(./obj_dir/Vdcache_tb)
status=$?
echo "$out"
if [ $status -ne 0 ]; then
	echo "simulation exited with status $status"
	exit 1
fi

if echo "$out" | grep -qx "All checks passed"; then
	exit 0
fi
exit 1

// ==== sim.f ====
logic/dcache_pkg.sv
logic/dcache_tags.sv
logic/dcache_data.sv
logic/dcache_ctrl.sv
logic/dcache_mem_port.sv
logic/dcache_top.sv
dv/clk_gen.sv
dv/mem_model.sv
dv/dcache_props.sv
dv/dcache_tb.sv
